// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eth_tx_dma_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
logic/eth_dma_pkg.sv
logic/eth_tx_bd_ring.sv
logic/eth_tx_frame_copy.sv
logic/eth_tx_dma.sv
verif/tb_clock_gen.sv
verif/eth_tx_dma_tb.sv

// ==== logic/eth_dma_pkg.sv ====
package eth_dma_pkg;

   // Descriptor memory and ring geometry
   localparam int BD_ADDR_W = 8;
   localparam int BD_NUM_W  = 7;

   // MAC transmit buffer byte address
   localparam int BUFFER_W = 11;

   // AXI read channel
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_LEN_W  = 8;

   // Width of the length field in a control word
   localparam int LEN_W = 16;

   // Largest burst, in single-byte beats
   localparam logic [LEN_W-1:0] MAX_BURST_LEN = 16;

   // Frame length as seen by the transmitter
   localparam int FRAME_LEN_W = 11;

   // Ethernet framing
   localparam logic [LEN_W-1:0] PREAMBLE_LEN  = 7;
   localparam logic [LEN_W-1:0] PRE_FRAME_LEN = PREAMBLE_LEN + 1'b1;
   localparam logic [7:0]       PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0]       SFD_BYTE      = 8'hD5;

   // Control word, bit 31 at the top
   typedef struct packed {
      logic [LEN_W-1:0] len;
      logic             ready;
      logic             irq;
      logic             wrap;
      logic             rsvd_12;
      logic             crc;
      logic [10:0]      rsvd_lo;
   } bd_ctrl_t;

   // One word from the descriptor memory, control word or buffer pointer
   typedef union packed {
      bd_ctrl_t    ctrl;
      logic [31:0] ptr;
   } bd_word_u;

   // Copy job handed from the ring to the copier
   typedef struct packed {
      logic [31:0]      ptr;
      logic [LEN_W-1:0] len;
      logic             crc;
   } copy_job_t;

   // Transmitter start information
   typedef struct packed {
      logic [FRAME_LEN_W-1:0] nbytes;
      logic                   crc_en;
   } tx_start_t;

   // Transmit buffer write port
   typedef struct packed {
      logic [BUFFER_W-1:0] addr;
      logic [7:0]          data;
      logic                wen;
   } buf_wr_t;

endpackage

// ==== logic/eth_tx_bd_ring.sv ====
`timescale 1ns/1ps

module eth_tx_bd_ring (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic                                 tx_en_i,
   input  logic [eth_dma_pkg::BD_NUM_W-1:0]     tx_bd_num_i,
   input  logic                                 tx_ready_i,
   output logic [eth_dma_pkg::BD_ADDR_W-1:0]    bd_addr_o,
   output logic                                 bd_wen_o,
   output logic [31:0]                          bd_wdata_o,
   input  eth_dma_pkg::bd_word_u                bd_rdata_i,
   output logic                                 job_valid_o,
   output eth_dma_pkg::copy_job_t               job_o,
   input  logic                                 copy_idle_i,
   input  logic                                 copy_done_i,
   output logic                                 tx_irq_o
);

   typedef enum logic [2:0] {
      POLL_REQ,
      POLL_CHK,
      PTR_REQ,
      PTR_CHK,
      DISPATCH,
      WAIT_DONE,
      WRITE_BACK
   } ring_state_e;

   ring_state_e                        state_q;
   logic [eth_dma_pkg::BD_NUM_W-1:0]   bd_num_q;
   logic [eth_dma_pkg::BD_NUM_W-1:0]   bd_num_next;
   logic [eth_dma_pkg::BD_NUM_W:0]     bd_num_inc;
   eth_dma_pkg::bd_ctrl_t              ctrl_q;
   eth_dma_pkg::bd_ctrl_t              wb_ctrl;
   logic [31:0]                        ptr_q;
   logic                               ptr_phase;

   // Pointer word sits right after the control word
   assign ptr_phase = (state_q == PTR_REQ) || (state_q == PTR_CHK);
   assign bd_addr_o = {bd_num_q, ptr_phase};

   always_comb begin
      wb_ctrl       = ctrl_q;
      wb_ctrl.ready = 1'b0;
   end

   assign bd_wen_o   = (state_q == WRITE_BACK);
   assign bd_wdata_o = wb_ctrl;
   assign tx_irq_o   = (state_q == WRITE_BACK) && ctrl_q.irq;

   // One-cycle job pulse as soon as both sides can take a frame
   assign job_valid_o = (state_q == DISPATCH) && tx_ready_i && copy_idle_i;

   assign job_o.ptr = ptr_q;
   assign job_o.len = ctrl_q.len;
   assign job_o.crc = ctrl_q.crc;

   // Next descriptor, wrap bit first, then ring size
   always_comb begin
      if (ctrl_q.wrap) begin
         bd_num_inc = '0;
      end else begin
         bd_num_inc = {1'b0, bd_num_q} + 1'b1;
      end
      if (bd_num_inc >= {1'b0, tx_bd_num_i}) begin
         bd_num_next = '0;
      end else begin
         bd_num_next = bd_num_inc[eth_dma_pkg::BD_NUM_W-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= POLL_REQ;
         bd_num_q <= '0;
      end else begin
         case (state_q)
            POLL_REQ: begin
               state_q <= POLL_CHK;
            end
            POLL_CHK: begin
               // Read data for the control word is valid here
               if (bd_rdata_i.ctrl.ready && tx_en_i) begin
                  state_q <= PTR_REQ;
               end else begin
                  state_q <= POLL_REQ;
               end
            end
            PTR_REQ: begin
               state_q <= PTR_CHK;
            end
            PTR_CHK: begin
               state_q <= DISPATCH;
            end
            DISPATCH: begin
               if (tx_ready_i && copy_idle_i) begin
                  state_q <= WAIT_DONE;
               end
            end
            WAIT_DONE: begin
               if (copy_done_i) begin
                  state_q <= WRITE_BACK;
               end
            end
            WRITE_BACK: begin
               bd_num_q <= bd_num_next;
               state_q  <= POLL_REQ;
            end
            default: begin
               state_q <= POLL_REQ;
            end
         endcase
      end
   end

   // Descriptor words as they come back from memory
   always_ff @(posedge clk_i) begin
      if (state_q == POLL_CHK) begin
         ctrl_q <= bd_rdata_i.ctrl;
      end
      if (state_q == PTR_CHK) begin
         ptr_q <= bd_rdata_i.ptr;
      end
   end

   // Status goes back only to a control word, right after the copy ended
   a_wb_ctrl_word: assert property (@(posedge clk_i) disable iff (arst_i)
      bd_wen_o |-> !bd_addr_o[0] && $past(copy_done_i));

   // Copier must leave idle once it has taken the job
   a_job_when_idle: assert property (@(posedge clk_i) disable iff (arst_i)
      job_valid_o |-> copy_idle_i ##1 !copy_idle_i);

endmodule

// ==== logic/eth_tx_dma.sv ====
`timescale 1ns/1ps

module eth_tx_dma (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic                                 tx_en_i,
   input  logic [eth_dma_pkg::BD_NUM_W-1:0]     tx_bd_num_i,
   output logic [eth_dma_pkg::BD_ADDR_W-1:0]    bd_addr_o,
   output logic                                 bd_wen_o,
   output logic [31:0]                          bd_wdata_o,
   input  eth_dma_pkg::bd_word_u                bd_rdata_i,
   output logic [eth_dma_pkg::AXI_ADDR_W-1:0]   axi_araddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]    axi_arlen_o,
   output logic                                 axi_arvalid_o,
   input  logic                                 axi_arready_i,
   input  logic [31:0]                          axi_rdata_i,
   input  logic                                 axi_rvalid_i,
   input  logic                                 axi_rlast_i,
   output logic                                 axi_rready_o,
   output eth_dma_pkg::buf_wr_t                 buf_wr_o,
   input  logic                                 tx_ready_i,
   output logic                                 send_o,
   output eth_dma_pkg::tx_start_t               tx_start_o,
   output logic                                 tx_irq_o
);

   // Between the descriptor ring and the frame copier
   logic                      job_valid;
   eth_dma_pkg::copy_job_t    job;
   logic                      copy_idle;
   logic                      copy_done;

   eth_tx_bd_ring eth_tx_bd_ring_inst (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .tx_en_i     (tx_en_i),
      .tx_bd_num_i (tx_bd_num_i),
      .tx_ready_i  (tx_ready_i),
      .bd_addr_o   (bd_addr_o),
      .bd_wen_o    (bd_wen_o),
      .bd_wdata_o  (bd_wdata_o),
      .bd_rdata_i  (bd_rdata_i),
      .job_valid_o (job_valid),
      .job_o       (job),
      .copy_idle_i (copy_idle),
      .copy_done_i (copy_done),
      .tx_irq_o    (tx_irq_o)
   );

   eth_tx_frame_copy eth_tx_frame_copy_inst (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .job_valid_i   (job_valid),
      .job_i         (job),
      .copy_idle_o   (copy_idle),
      .copy_done_o   (copy_done),
      .axi_araddr_o  (axi_araddr_o),
      .axi_arlen_o   (axi_arlen_o),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_arready_i (axi_arready_i),
      .axi_rdata_i   (axi_rdata_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rlast_i   (axi_rlast_i),
      .axi_rready_o  (axi_rready_o),
      .buf_wr_o      (buf_wr_o),
      .send_o        (send_o),
      .tx_start_o    (tx_start_o)
   );

endmodule

// ==== logic/eth_tx_frame_copy.sv ====
`timescale 1ns/1ps

module eth_tx_frame_copy (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic                                 job_valid_i,
   input  eth_dma_pkg::copy_job_t               job_i,
   output logic                                 copy_idle_o,
   output logic                                 copy_done_o,
   output logic [eth_dma_pkg::AXI_ADDR_W-1:0]   axi_araddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]    axi_arlen_o,
   output logic                                 axi_arvalid_o,
   input  logic                                 axi_arready_i,
   input  logic [31:0]                          axi_rdata_i,
   input  logic                                 axi_rvalid_i,
   input  logic                                 axi_rlast_i,
   output logic                                 axi_rready_o,
   output eth_dma_pkg::buf_wr_t                 buf_wr_o,
   output logic                                 send_o,
   output eth_dma_pkg::tx_start_t               tx_start_o
);

   typedef enum logic [1:0] {
      FILL_PRE,
      IDLE,
      REQ_BURST,
      RECV_BURST
   } copy_state_e;

   copy_state_e                           state_q;
   // Preamble index during the fill, frame bytes copied afterwards
   logic [eth_dma_pkg::LEN_W-1:0]         cnt_q;
   eth_dma_pkg::copy_job_t                job_q;
   logic [eth_dma_pkg::LEN_W-1:0]         remain;
   logic [eth_dma_pkg::LEN_W-1:0]         burst_len;
   logic [eth_dma_pkg::LEN_W-1:0]         burst_len_m1;
   logic [eth_dma_pkg::AXI_ADDR_W-1:0]    byte_addr;
   logic [eth_dma_pkg::LEN_W:0]           wr_addr_full;
   logic [eth_dma_pkg::LEN_W-1:0]         nbytes_full;
   logic [7:0]                            lane_byte;
   logic                                  buf_wen_q;
   logic [eth_dma_pkg::BUFFER_W-1:0]      buf_addr_q;
   logic [7:0]                            buf_data_q;
   logic                                  send_q;
   logic                                  done_q;
   eth_dma_pkg::tx_start_t                tx_start_q;

   assign remain       = job_q.len - cnt_q;
   assign burst_len    = (remain > eth_dma_pkg::MAX_BURST_LEN) ?
                         eth_dma_pkg::MAX_BURST_LEN : remain;
   assign burst_len_m1 = burst_len - 1'b1;
   assign byte_addr    = job_q.ptr +
      {{(eth_dma_pkg::AXI_ADDR_W-eth_dma_pkg::LEN_W){1'b0}}, cnt_q};
   assign wr_addr_full = {1'b0, eth_dma_pkg::PRE_FRAME_LEN} + {1'b0, cnt_q};
   assign nbytes_full  = eth_dma_pkg::PRE_FRAME_LEN + job_q.len;

   // Byte beats arrive on the lane of their own address
   assign lane_byte = axi_rdata_i[{byte_addr[1:0], 3'b000} +: 8];

   // Request stays up with a fixed address until it is accepted
   assign axi_arvalid_o = (state_q == REQ_BURST) && (remain != '0);
   assign axi_araddr_o  = byte_addr;
   assign axi_arlen_o   = burst_len_m1[eth_dma_pkg::AXI_LEN_W-1:0];
   assign axi_rready_o  = (state_q == RECV_BURST);

   assign copy_idle_o = (state_q == IDLE);
   assign copy_done_o = done_q;
   assign send_o      = send_q;
   assign tx_start_o  = tx_start_q;

   assign buf_wr_o.addr = buf_addr_q;
   assign buf_wr_o.data = buf_data_q;
   assign buf_wr_o.wen  = buf_wen_q;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q   <= FILL_PRE;
         cnt_q     <= '0;
         buf_wen_q <= 1'b0;
         send_q    <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         buf_wen_q <= 1'b0;
         send_q    <= 1'b0;
         done_q    <= 1'b0;
         case (state_q)
            FILL_PRE: begin
               buf_wen_q <= 1'b1;
               cnt_q     <= cnt_q + 1'b1;
               if (cnt_q == eth_dma_pkg::PRE_FRAME_LEN - 1'b1) begin
                  state_q <= IDLE;
               end
            end
            REQ_BURST: begin
               if (remain == '0) begin
                  // Whole frame is in the buffer, start the MAC
                  send_q  <= 1'b1;
                  done_q  <= 1'b1;
                  state_q <= IDLE;
               end else if (axi_arready_i) begin
                  state_q <= RECV_BURST;
               end
            end
            RECV_BURST: begin
               if (axi_rvalid_i) begin
                  buf_wen_q <= 1'b1;
                  cnt_q     <= cnt_q + 1'b1;
                  if (axi_rlast_i) begin
                     state_q <= REQ_BURST;
                  end
               end
            end
            default: ;
         endcase
         // The ring only sends a job while this stage is idle
         if (job_valid_i) begin
            cnt_q   <= '0;
            state_q <= REQ_BURST;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (job_valid_i) begin
         job_q <= job_i;
      end
      if (state_q == FILL_PRE) begin
         buf_addr_q <= cnt_q[eth_dma_pkg::BUFFER_W-1:0];
         if (cnt_q == eth_dma_pkg::PREAMBLE_LEN) begin
            buf_data_q <= eth_dma_pkg::SFD_BYTE;
         end else begin
            buf_data_q <= eth_dma_pkg::PREAMBLE_BYTE;
         end
      end else begin
         buf_addr_q <= wr_addr_full[eth_dma_pkg::BUFFER_W-1:0];
         buf_data_q <= lane_byte;
      end
      if (state_q == REQ_BURST && remain == '0) begin
         tx_start_q.nbytes <= nbytes_full[eth_dma_pkg::FRAME_LEN_W-1:0];
         tx_start_q.crc_en <= job_q.crc;
      end
   end

   a_ar_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_arvalid_o && !axi_arready_i |=>
         axi_arvalid_o && $stable(axi_araddr_o) && $stable(axi_arlen_o));

   // Frame must fit behind the preamble
   a_buf_addr_range: assert property (@(posedge clk_i) disable iff (arst_i)
      (state_q == RECV_BURST) && axi_rvalid_i |->
         wr_addr_full < (1 << eth_dma_pkg::BUFFER_W));

endmodule

// ==== verif/eth_tx_dma_tb.sv ====
`timescale 1ns/1ps

module eth_tx_dma_tb;

   typedef enum int {EV_BUF_WR, EV_SEND, EV_WB} event_e;

   logic                                 clk;
   logic                                 arst;
   logic                                 tx_en_i;
   logic [eth_dma_pkg::BD_NUM_W-1:0]     tx_bd_num_i;
   logic                                 tx_ready_i;
   logic [eth_dma_pkg::BD_ADDR_W-1:0]    bd_addr_o;
   logic                                 bd_wen_o;
   logic [31:0]                          bd_wdata_o;
   eth_dma_pkg::bd_word_u                bd_rdata_i = '0;
   logic [eth_dma_pkg::AXI_ADDR_W-1:0]   axi_araddr_o;
   logic [eth_dma_pkg::AXI_LEN_W-1:0]    axi_arlen_o;
   logic                                 axi_arvalid_o;
   logic                                 axi_arready_i = 1'b0;
   logic [31:0]                          axi_rdata_i = '0;
   logic                                 axi_rvalid_i = 1'b0;
   logic                                 axi_rlast_i = 1'b0;
   logic                                 axi_rready_o;
   eth_dma_pkg::buf_wr_t                 buf_wr_o;
   logic                                 send_o;
   eth_dma_pkg::tx_start_t               tx_start_o;
   logic                                 tx_irq_o;

   logic [31:0]   bd_mem [0:255];
   logic [7:0]    axi_mem [0:4095];
   logic [7:0]    tx_buf [0:2047];
   integer        seed = 32'hd1de;
   logic          burst_active = 1'b0;
   logic [31:0]   beat_addr;
   int            beats_left;
   int            buf_writes = 0;
   int            high_writes = 0;
   int            send_count = 0;
   int            irq_count = 0;
   int            wb_count = 0;
   int            burst_count = 0;
   int            base_send;
   int            base_wb;
   int            base_irq;
   int            base_burst;
   logic [31:0]   burst_addr_log [$];
   logic [7:0]    burst_len_log [$];
   logic [10:0]   sent_nbytes [$];
   logic          sent_crc [$];
   int            wb_bd [$];

   tb_clock_gen clock_gen_inst (
      .clk_o  (clk),
      .arst_o (arst)
   );

   eth_tx_dma eth_tx_dma_inst (
      .clk_i  (clk),
      .arst_i (arst),
      .*
   );

   // Descriptor memory, AXI slave and transmit buffer, all on the falling edge
   always @(negedge clk) begin
      logic [11:0] word_addr;
      if (bd_wen_o) begin
         bd_mem[bd_addr_o] <= bd_wdata_o;
         wb_bd.push_back(bd_addr_o >> 1);
         wb_count = wb_count + 1;
      end
      bd_rdata_i = bd_mem[bd_addr_o];
      if (buf_wr_o.wen) begin
         tx_buf[buf_wr_o.addr] = buf_wr_o.data;
         buf_writes = buf_writes + 1;
         if (buf_wr_o.addr >= 8) begin
            high_writes = high_writes + 1;
         end
      end
      if (send_o) begin
         sent_nbytes.push_back(tx_start_o.nbytes);
         sent_crc.push_back(tx_start_o.crc_en);
         send_count = send_count + 1;
      end
      if (tx_irq_o) begin
         irq_count = irq_count + 1;
      end
      axi_arready_i = 1'b0;
      axi_rvalid_i  = 1'b0;
      axi_rlast_i   = 1'b0;
      // Random gaps on both the address and the data channel
      if (burst_active && axi_rready_o) begin
         if (($random(seed) & 3) != 0) begin
            word_addr    = beat_addr[11:0] & 12'hffc;
            axi_rdata_i  = {axi_mem[word_addr + 12'd3], axi_mem[word_addr + 12'd2],
                            axi_mem[word_addr + 12'd1], axi_mem[word_addr]};
            axi_rvalid_i = 1'b1;
            axi_rlast_i  = (beats_left == 1);
            beat_addr    = beat_addr + 1;
            beats_left   = beats_left - 1;
            burst_active = (beats_left != 0);
         end
      end else if (!burst_active && axi_arvalid_o) begin
         if (($random(seed) & 3) != 0) begin
            axi_arready_i = 1'b1;
            burst_active  = 1'b1;
            beat_addr     = axi_araddr_o;
            beats_left    = axi_arlen_o + 1;
            burst_addr_log.push_back(axi_araddr_o);
            burst_len_log.push_back(axi_arlen_o);
            burst_count   = burst_count + 1;
         end
      end
   end

   task automatic end_in_failure(input string reason);
      $display("%s", reason);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         end_in_failure($sformatf("FAILED at time %0t: %s is %0h, expected %0h",
                                  $time, name, got, expected));
      end
   endtask

   function automatic int event_count(input event_e which);
      case (which)
         EV_BUF_WR: return buf_writes;
         EV_SEND:   return send_count;
         default:   return wb_count;
      endcase
   endfunction

   task automatic wait_for_events(input event_e which, input int target, input string what);
      int cycles;
      cycles = 0;
      while (event_count(which) < target && cycles < 3000) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      if (event_count(which) < target) begin
         end_in_failure($sformatf("Timed out after %0d cycles waiting for %s", cycles, what));
      end
   endtask

   // No AXI request and no send over a window of cycles
   task automatic expect_quiet(input int cycles, input string what);
      int start_bursts;
      int start_sends;
      start_bursts = burst_count;
      start_sends  = send_count;
      repeat (cycles) @(posedge clk);
      check_value({what, ": AXI bursts"}, burst_count, start_bursts);
      check_value({what, ": send_o pulses"}, send_count, start_sends);
   endtask

   // Length 31:16, ready 15, irq 14, wrap 13, reserved 12, crc 11, reserved 10:0
   function automatic logic [31:0] ctrl_word(input int len, input bit ready, input bit irq,
                                             input bit wrap, input bit crc, input int n);
      return {len[15:0], ready, irq, wrap, n[0], crc, 11'h5a0 ^ n[10:0]};
   endfunction

   task automatic mark_counts();
      base_send  = send_count;
      base_wb    = wb_count;
      base_irq   = irq_count;
      base_burst = burst_count;
   endtask

   task automatic arm_desc(input int n, input logic [31:0] ctrl, input logic [31:0] ptr);
      @(negedge clk);
      bd_mem[2*n+1] <= ptr;
      bd_mem[2*n]   <= ctrl;
   endtask

   task automatic check_frame(input int n, input logic [31:0] ctrl, input logic [31:0] ptr);
      int len;
      int offset;
      int chunk;
      int idx;
      len = ctrl[31:16];
      wait_for_events(EV_SEND, base_send + 1, "send_o");
      check_value("tx_start_o.nbytes", sent_nbytes[base_send], 8 + len);
      check_value("tx_start_o.crc_en", sent_crc[base_send], ctrl[11]);
      // Bursts of up to 16 bytes walk the frame from the pointer
      offset = 0;
      idx    = base_burst;
      while (offset < len) begin
         chunk = (len - offset > 16) ? 16 : len - offset;
         check_value("axi_araddr_o", burst_addr_log[idx], ptr + offset);
         check_value("axi_arlen_o", burst_len_log[idx], chunk - 1);
         offset = offset + chunk;
         idx    = idx + 1;
      end
      check_value("AXI burst count", burst_count, idx);
      for (int k = 0; k < len; k++) begin
         check_value($sformatf("tx_buf[%0d]", 8 + k), tx_buf[8 + k], axi_mem[(ptr + k) & 4095]);
      end
      wait_for_events(EV_WB, base_wb + 1, "descriptor writeback");
      check_value("send_o pulses", send_count, base_send + 1);
      check_value("written descriptor", wb_bd[base_wb], n);
      check_value($sformatf("bd_mem[%0d]", 2 * n), bd_mem[2*n], ctrl & ~32'h8000);
      check_value("tx_irq_o pulses", irq_count - base_irq, ctrl[14]);
   endtask

   task automatic send_frame(input int n, input int len, input logic [31:0] ptr,
                             input bit irq, input bit crc, input bit wrap);
      logic [31:0] ctrl;
      ctrl = ctrl_word(len, 1'b1, irq, wrap, crc, n);
      mark_counts();
      arm_desc(n, ctrl, ptr);
      check_frame(n, ctrl, ptr);
   endtask

   task automatic test_preamble_fill();
      wait_for_events(EV_BUF_WR, 8, "preamble writes");
      repeat (20) @(posedge clk);
      check_value("buffer writes after reset", buf_writes, 8);
      for (int i = 0; i < 7; i++) begin
         check_value($sformatf("tx_buf[%0d]", i), tx_buf[i], 8'h55);
      end
      check_value("tx_buf[7]", tx_buf[7], 8'hd5);
      check_value("writes at address 8 and up", high_writes, 0);
   endtask

   task automatic test_frame_copy();
      @(negedge clk);
      tx_en_i = 1'b1;
      // Pointer ends in 01, so a full burst then four bytes
      send_frame(0, 20, 32'h0000_0101, 1'b1, 1'b1, 1'b0);
      check_value("first burst axi_arlen_o", burst_len_log[base_burst], 15);
      check_value("second burst axi_arlen_o", burst_len_log[base_burst + 1], 3);
      check_value("second burst axi_araddr_o", burst_addr_log[base_burst + 1],
                  32'h0000_0111);
   endtask

   task automatic test_tx_start();
      send_frame(1, 33, 32'h0000_0203, 1'b0, 1'b0, 1'b0);
      send_frame(2, 5, 32'h0000_032e, 1'b1, 1'b1, 1'b0);
   endtask

   task automatic test_writeback();
      send_frame(0, 17, 32'h0000_040a, 1'b0, 1'b1, 1'b0);
      send_frame(1, 9, 32'h0000_0517, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic test_ring_advance();
      // Descriptor 2 is the last one of a three-entry ring
      send_frame(2, 12, 32'h0000_0600, 1'b0, 1'b0, 1'b0);
      mark_counts();
      for (int i = 0; i < 3; i++) begin
         arm_desc(i, ctrl_word(3 + i, 1'b1, 1'b0, 1'b0, 1'b0, i), 32'h700 + 16 * i);
      end
      wait_for_events(EV_WB, base_wb + 3, "three queued frames");
      for (int i = 0; i < 3; i++) begin
         check_value("written descriptor", wb_bd[base_wb + i], i);
         check_value("tx_start_o.nbytes", sent_nbytes[base_send + i], 11 + i);
      end
      send_frame(0, 6, 32'h0000_0730, 1'b0, 1'b0, 1'b0);
      send_frame(1, 7, 32'h0000_0741, 1'b0, 1'b1, 1'b1);
      send_frame(0, 8, 32'h0000_0752, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic test_hold_off();
      logic [31:0] ctrl;
      arm_desc(1, ctrl_word(10, 1'b0, 1'b1, 1'b0, 1'b1, 1), 32'h0000_0803);
      expect_quiet(100, "ready bit clear");
      @(negedge clk);
      tx_en_i = 1'b0;
      ctrl = ctrl_word(10, 1'b1, 1'b1, 1'b0, 1'b1, 1);
      mark_counts();
      arm_desc(1, ctrl, 32'h0000_0803);
      expect_quiet(100, "tx_en_i low");
      @(negedge clk);
      tx_en_i = 1'b1;
      check_frame(1, ctrl, 32'h0000_0803);
   endtask

   initial begin
      tx_en_i     = 1'b0;
      tx_ready_i  = 1'b1;
      tx_bd_num_i = 7'd3;
      for (int i = 0; i < 256; i++) begin
         bd_mem[i] <= '0;
      end
      for (int i = 0; i < 4096; i++) begin
         axi_mem[i] = $random(seed);
      end
      test_preamble_fill();
      test_frame_copy();
      test_tx_start();
      test_writeback();
      test_ring_advance();
      test_hold_off();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic arst_o
);

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;
      end
   end

   // Reset over the first four rising edges, released on a falling edge
   initial begin
      arst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      arst_o = 1'b0;
   end

endmodule
